//--- Makefile
# Verilator flow for the RV32I SoC testbench

VERILATOR ?= verilator
TOP       ?= riscv_soc_tb
SEED      ?= 22060
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only if the pass line shows up in the simulation output
sim:
	$(VERILATOR) --binary $(VFLAGS) -j 0 -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
+incdir+source
source/riscv_pkg.sv
source/riscv_if.sv
source/riscv_ex.sv
source/riscv_core.sv
source/mem_arbiter.sv
source/shared_sram.sv
source/riscv_soc.sv
testbench/riscv_soc_tb.sv

//--- source/mem_arbiter.sv
// Fixed priority host over data over fetch; a busy host can starve the core
`timescale 1ns/1ps
`include "riscv_params.svh"

module mem_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   host_req,
  input  logic                   host_we,
  input  logic [`MEM_AW-1:0]     host_addr,
  input  riscv_pkg::word_t       host_wdata,
  output logic                   host_ack,
  input  logic                   data_req,
  input  logic                   data_we,
  input  logic [`MEM_AW-1:0]     data_addr,
  input  riscv_pkg::word_t       data_wdata,
  output logic                   data_ack,
  input  logic                   fetch_req,
  input  logic                   fetch_we,
  input  logic [`MEM_AW-1:0]     fetch_addr,
  input  riscv_pkg::word_t       fetch_wdata,
  output logic                   fetch_ack,
  output logic                   mem_req,
  output logic                   mem_we,
  output logic [`MEM_AW-1:0]     mem_addr,
  output riscv_pkg::word_t       mem_wdata,
  input  logic                   mem_ack
);

  // One-hot grant, bit per requester index
  logic [2:0] grant;
  logic [2:0] reqs;

  assign reqs[riscv_pkg::REQ_HOST]  = host_req;
  assign reqs[riscv_pkg::REQ_DATA]  = data_req;
  assign reqs[riscv_pkg::REQ_FETCH] = fetch_req;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      grant <= '0;
    else if (grant == '0)
    begin
      // Pick by priority
      if (host_req)
        grant <= 3'b1 << riscv_pkg::REQ_HOST;
      else if (data_req)
        grant <= 3'b1 << riscv_pkg::REQ_DATA;
      else if (fetch_req)
        grant <= 3'b1 << riscv_pkg::REQ_FETCH;
    end
    // Release only after full four-phase completion
    else if (!(|(grant & reqs)) && !mem_ack)
      grant <= '0;
  end

  // Route granted port
  always_comb
  begin
    mem_req   = |(grant & reqs);
    mem_we    = fetch_we;
    mem_addr  = fetch_addr;
    mem_wdata = fetch_wdata;
    if (grant[riscv_pkg::REQ_HOST])
    begin
      mem_we    = host_we;
      mem_addr  = host_addr;
      mem_wdata = host_wdata;
    end
    else if (grant[riscv_pkg::REQ_DATA])
    begin
      mem_we    = data_we;
      mem_addr  = data_addr;
      mem_wdata = data_wdata;
    end
  end

  assign host_ack  = mem_ack && grant[riscv_pkg::REQ_HOST];
  assign data_ack  = mem_ack && grant[riscv_pkg::REQ_DATA];
  assign fetch_ack = mem_ack && grant[riscv_pkg::REQ_FETCH];

  // Grant holds across every edge with memory ack up
  a_grant_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_ack |=> $stable(grant));

endmodule

//--- source/riscv_core.sv
// Two instructions in flight at most, no forwarding needed since execute holds one at a time
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  input  logic                   fetch_ack,
  input  riscv_pkg::word_t       fetch_rdata,
  input  logic                   data_ack,
  input  riscv_pkg::word_t       data_rdata,
  output logic                   fetch_req,
  output logic [`MEM_AW-1:0]     fetch_addr,
  output logic                   data_req,
  output logic                   data_we,
  output logic [`MEM_AW-1:0]     data_addr,
  output riscv_pkg::word_t       data_wdata,
  output logic                   halted
);

  riscv_pkg::word_t regs [`NREGS];
  riscv_pkg::word_t fetched_instr, fetched_pc, redirect_pc, rd_val;
  riscv_pkg::word_t id_instr, id_pc, rs1_val, rs2_val;
  logic [4:0]       rs1, rs2, rd;
  logic             fetched_valid, id_valid, take, ex_ready, redirect, rd_we;

  // Move buffered word into execute once it frees up
  assign take = run && !halted && !redirect && fetched_valid && (!id_valid || ex_ready);

  ////////////////////
  // Hand-off register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      id_valid <= 1'b0;
    else if (!run || redirect)
      id_valid <= 1'b0;
    else if (take)
      id_valid <= 1'b1;
    else if (ex_ready)
      id_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      id_instr <= fetched_instr;
      id_pc    <= fetched_pc;
    end
  end

  ////////////////////
  // Register file
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rd_we)
      regs[rd] <= rd_val;
  end

  // x0 hardwired to zero
  assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

  riscv_if if_unit (
    .clk, .rst_n, .run, .redirect, .redirect_pc, .take,
    .fetch_ack, .fetch_rdata, .fetch_req, .fetch_addr,
    .fetched_instr, .fetched_pc, .fetched_valid
  );

  // Halted core executes nothing more
  riscv_ex ex_unit (
    .clk, .rst_n, .run,
    .instr       ( id_instr             ),
    .pc          ( id_pc                ),
    .instr_valid ( id_valid && !halted  ),
    .rs1_val, .rs2_val, .data_ack, .data_rdata,
    .rs1, .rs2, .ex_ready, .rd_we, .rd, .rd_val,
    .redirect, .redirect_pc,
    .data_req, .data_we, .data_addr, .data_wdata, .halted
  );

endmodule

//--- source/riscv_ex.sv
// Single-issue execute; LW/SW are word only with no misalign or illegal-instruction trap
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_ex (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  input  riscv_pkg::word_t       instr,
  input  riscv_pkg::word_t       pc,
  input  logic                   instr_valid,
  input  riscv_pkg::word_t       rs1_val,
  input  riscv_pkg::word_t       rs2_val,
  input  logic                   data_ack,
  input  riscv_pkg::word_t       data_rdata,
  output logic [4:0]             rs1,
  output logic [4:0]             rs2,
  output logic                   ex_ready,
  output logic                   rd_we,
  output logic [4:0]             rd,
  output riscv_pkg::word_t       rd_val,
  output logic                   redirect,
  output riscv_pkg::word_t       redirect_pc,
  output logic                   data_req,
  output logic                   data_we,
  output logic [`MEM_AW-1:0]     data_addr,
  output riscv_pkg::word_t       data_wdata,
  output logic                   halted
);

  localparam logic [1:0] MS_IDLE = 2'd0;
  localparam logic [1:0] MS_REQ  = 2'd1;
  localparam logic [1:0] MS_WAIT = 2'd2;
  localparam logic [1:0] MS_DONE = 2'd3;

  riscv_pkg::opcode_e opcode;
  riscv_pkg::alu_op_e alu_op;
  riscv_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
  riscv_pkg::word_t   alu_b, alu_r, mem_byte_addr, load_q;
  logic [2:0]         funct3;
  logic [1:0]         mstate;
  logic               wb_en, is_mem, is_store, is_jal, is_ebreak, take_br;

  ////////////////////
  // Decode
  ////////////////////

  assign opcode = riscv_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // Immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb
  begin
    alu_op    = riscv_pkg::ALU_ADD;
    alu_b     = rs2_val;
    wb_en     = 1'b0;
    is_mem    = 1'b0;
    is_store  = 1'b0;
    is_jal    = 1'b0;
    is_ebreak = 1'b0;
    take_br   = 1'b0;
    case (opcode)
      riscv_pkg::OP_LUI:
      begin
        alu_op = riscv_pkg::ALU_PASSB;
        alu_b  = imm_u;
        wb_en  = 1'b1;
      end
      riscv_pkg::OP_IMM:
      begin
        alu_b = imm_i;
        // Only ADDI, XORI, ORI, ANDI write back
        wb_en = (funct3 == 3'b000) || (funct3 == 3'b100) || (funct3 >= 3'b110);
        case (funct3)
          3'b100:  alu_op = riscv_pkg::ALU_XOR;
          3'b110:  alu_op = riscv_pkg::ALU_OR;
          3'b111:  alu_op = riscv_pkg::ALU_AND;
          default: alu_op = riscv_pkg::ALU_ADD;
        endcase
      end
      riscv_pkg::OP_REG:
      begin
        wb_en = 1'b1;
        case (funct3)
          3'b000:  alu_op = instr[30] ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
          3'b010:  alu_op = riscv_pkg::ALU_SLT;
          3'b100:  alu_op = riscv_pkg::ALU_XOR;
          3'b110:  alu_op = riscv_pkg::ALU_OR;
          3'b111:  alu_op = riscv_pkg::ALU_AND;
          default: wb_en  = 1'b0;
        endcase
      end
      riscv_pkg::OP_LOAD:
      begin
        is_mem = 1'b1;
        wb_en  = 1'b1;
      end
      riscv_pkg::OP_STORE:
      begin
        is_mem   = 1'b1;
        is_store = 1'b1;
      end
      // BEQ on funct3 000, BNE on 001
      riscv_pkg::OP_BRANCH:
        take_br = (funct3 == 3'b000) ? (rs1_val == rs2_val) :
                  (funct3 == 3'b001) ? (rs1_val != rs2_val) : 1'b0;
      riscv_pkg::OP_JAL:
      begin
        is_jal  = 1'b1;
        wb_en   = 1'b1;
        take_br = 1'b1;
      end
      riscv_pkg::OP_SYSTEM:
        is_ebreak = (instr == 32'h0010_0073);
      default: ;
    endcase
  end

  ////////////////////
  // ALU and branch
  ////////////////////

  always_comb
  begin
    case (alu_op)
      riscv_pkg::ALU_SUB:   alu_r = rs1_val - alu_b;
      riscv_pkg::ALU_AND:   alu_r = rs1_val & alu_b;
      riscv_pkg::ALU_OR:    alu_r = rs1_val | alu_b;
      riscv_pkg::ALU_XOR:   alu_r = rs1_val ^ alu_b;
      riscv_pkg::ALU_SLT:   alu_r = {31'd0, $signed(rs1_val) < $signed(alu_b)};
      riscv_pkg::ALU_PASSB: alu_r = alu_b;
      default:              alu_r = rs1_val + alu_b;
    endcase
  end

  // Memory ops retire after the full handshake
  assign ex_ready    = instr_valid && (!is_mem || (mstate == MS_DONE));
  assign redirect    = ex_ready && take_br;
  assign redirect_pc = pc + (is_jal ? imm_j : imm_b);

  // Writeback, x0 never written
  assign rd_we  = ex_ready && wb_en && (rd != 5'd0);
  assign rd_val = is_jal ? pc + 32'd4 : (is_mem ? load_q : alu_r);

  ////////////////////
  // Data master
  ////////////////////

  assign mem_byte_addr = rs1_val + (is_store ? imm_s : imm_i);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mstate   <= MS_IDLE;
      data_req <= 1'b0;
      halted   <= 1'b0;
    end
    else
    begin
      case (mstate)
        MS_IDLE:
          if (instr_valid && is_mem)
          begin
            data_req <= 1'b1;
            mstate   <= MS_REQ;
          end
        MS_REQ:
          if (data_ack)
          begin
            data_req <= 1'b0;
            mstate   <= MS_WAIT;
          end
        // Wait for responder to release ack
        MS_WAIT:
          if (!data_ack)
            mstate <= MS_DONE;
        default:
          mstate <= MS_IDLE;
      endcase

      // Sticky until run drops
      if (!run)
        halted <= 1'b0;
      else if (ex_ready && is_ebreak)
        halted <= 1'b1;
    end
  end

  // Request payload and load data
  always_ff @(posedge clk)
  begin
    if (mstate == MS_IDLE)
    begin
      data_we    <= is_store;
      data_addr  <= mem_byte_addr[`MEM_AW+1:2];
      data_wdata <= rs2_val;
    end
    if (mstate == MS_REQ && data_ack)
      load_q <= data_rdata;
  end

  // Load or store retires only once the responder has released ack
  a_mem_retire_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_ready && is_mem) |-> !data_ack);

endmodule

//--- source/riscv_if.sv
// One-word fetch buffer, no prefetch beyond it; a fetch in flight at redirect or stop is dropped
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_if (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  input  logic                   redirect,
  input  riscv_pkg::word_t       redirect_pc,
  input  logic                   take,
  input  logic                   fetch_ack,
  input  riscv_pkg::word_t       fetch_rdata,
  output logic                   fetch_req,
  output logic [`MEM_AW-1:0]     fetch_addr,
  output riscv_pkg::word_t       fetched_instr,
  output riscv_pkg::word_t       fetched_pc,
  output logic                   fetched_valid
);

  riscv_pkg::word_t pc;
  riscv_pkg::word_t req_pc;
  logic             discard;
  logic             landing;

  // Word returned on this edge
  assign landing    = fetch_req && fetch_ack;
  // Address held stable for the whole handshake
  assign fetch_addr = req_pc[`MEM_AW+1:2];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc            <= `PC_INIT;
      req_pc        <= `PC_INIT;
      fetch_req     <= 1'b0;
      discard       <= 1'b0;
      fetched_valid <= 1'b0;
      fetched_instr <= '0;
      fetched_pc    <= '0;
    end
    else
    begin
      // Drop req once ack seen
      if (landing)
        fetch_req <= 1'b0;

      if (!run || redirect)
      begin
        // Restart point, buffer emptied
        pc            <= run ? redirect_pc : `PC_INIT;
        fetched_valid <= 1'b0;
        // Word still owed by memory gets thrown away
        discard       <= fetch_req && !fetch_ack;
      end
      else
      begin
        if (take)
          fetched_valid <= 1'b0;

        if (landing)
        begin
          discard <= 1'b0;
          if (!discard)
          begin
            fetched_instr <= fetch_rdata;
            fetched_pc    <= req_pc;
            fetched_valid <= 1'b1;
            pc            <= req_pc + 32'd4;
          end
        end
        // Start next fetch only with an empty buffer and idle bus
        else if (!fetch_req && !fetch_ack && !fetched_valid && !discard)
        begin
          fetch_req <= 1'b1;
          req_pc    <= pc;
        end
      end
    end
  end

  // Four-phase rule, no new req over a live ack
  a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fetch_req) |-> !fetch_ack);

endmodule

//--- source/riscv_params.svh
// Word-addressed memory only; MEM_AW must equal log2(MEM_WORDS), PC_INIT must be word aligned
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// Data path and address width
`define XLEN 32

// Shared memory depth in words
`define MEM_WORDS 256

// Word address width
`define MEM_AW 8

// Reset PC, byte address
`define PC_INIT 32'h0000_0000

// Integer register count
`define NREGS 32

`endif

//--- source/riscv_pkg.sv
// RV32I subset types only; unlisted opcodes are not decoded and execute as no-ops
`include "riscv_params.svh"

package riscv_pkg;

  // One machine word
  typedef logic [`XLEN-1:0] word_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU operation picked by decode
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASSB
  } alu_op_e;

  // Arbiter port index, also the priority order
  typedef enum logic [1:0] {
    REQ_HOST  = 2'd0,
    REQ_DATA  = 2'd1,
    REQ_FETCH = 2'd2
  } requester_e;

endpackage

//--- source/riscv_soc.sv
// Host must follow the four-phase rule and should load programs only while run is low
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_soc (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  input  logic                   host_req,
  input  logic                   host_we,
  input  logic [`MEM_AW-1:0]     host_addr,
  input  riscv_pkg::word_t       host_wdata,
  output logic                   host_ack,
  output riscv_pkg::word_t       host_rdata,
  output logic                   halted
);

  logic               fetch_req, fetch_ack, data_req, data_we, data_ack;
  logic               mem_req, mem_we, mem_ack;
  logic [`MEM_AW-1:0] fetch_addr, data_addr, mem_addr;
  riscv_pkg::word_t   data_wdata, mem_wdata, mem_rdata;

  // Read data broadcast to every port
  assign host_rdata = mem_rdata;

  riscv_core core_i (
    .clk, .rst_n, .run,
    .fetch_ack, .fetch_rdata ( mem_rdata ),
    .data_ack,  .data_rdata  ( mem_rdata ),
    .fetch_req, .fetch_addr,
    .data_req, .data_we, .data_addr, .data_wdata, .halted
  );

  // Fetch port is read only
  mem_arbiter arb_i (
    .clk, .rst_n,
    .host_req, .host_we, .host_addr, .host_wdata, .host_ack,
    .data_req, .data_we, .data_addr, .data_wdata, .data_ack,
    .fetch_req, .fetch_we ( 1'b0 ), .fetch_addr, .fetch_wdata ( '0 ), .fetch_ack,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack
  );

  shared_sram sram_i (
    .clk, .rst_n,
    .req ( mem_req ), .we ( mem_we ), .addr ( mem_addr ), .wdata ( mem_wdata ),
    .ack ( mem_ack ), .rdata ( mem_rdata )
  );

endmodule

//--- source/shared_sram.sv
// Single port, word addressed, one access per four-phase transaction; contents not reset
`timescale 1ns/1ps
`include "riscv_params.svh"

module shared_sram (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  logic                   we,
  input  logic [`MEM_AW-1:0]     addr,
  input  riscv_pkg::word_t       wdata,
  output logic                   ack,
  output riscv_pkg::word_t       rdata
);

  riscv_pkg::word_t mem [`MEM_WORDS];

  // ack follows req by one cycle both ways
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ack <= 1'b0;
    else
      ack <= req;
  end

  // Access on the edge that raises ack
  always_ff @(posedge clk)
  begin
    if (req && !ack)
    begin
      if (we)
        mem[addr] <= wdata;
      else
        rdata <= mem[addr];
    end
  end

  // Requester keeps req up until ack answers
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (req && !ack) |=> req);

endmodule

//--- testbench/program_stim.txt
# cmd addr data: W writes data at word addr, R reads word addr and expects data
# G base count runs until halted while polling count words from base; S drops run
# Host write and readback
W FF A5A5A5A5
W F0 0F0F0F0F
W 40 13572468
R FF A5A5A5A5
R F0 0F0F0F0F
R 40 13572468
# Program, word address is byte PC / 4
# ALU section: lui, addi, add, sub, and, or, xor, slt, andi, ori, xori, addi to x0
W 00 123450B7
W 01 67808093
W 02 FF000113
W 03 002081B3
W 04 40208233
W 05 0020F2B3
W 06 0020E333
W 07 0020C3B3
W 08 00112433
W 09 0020A4B3
W 0A 0FF0F513
W 0B 55506593
W 0C FFF0C613
W 0D 07B00013
# Stores x3..x12, x0, x1 to bytes 0x200..0x22C
W 0E 20302023
W 0F 20402223
W 10 20502423
W 11 20602623
W 12 20702823
W 13 20802A23
W 14 20902C23
W 15 20A02E23
W 16 22B02023
W 17 22C02223
W 18 22002423
W 19 22102623
# lw x13, x14 then sum and difference stored at 0x308, 0x30C
W 1A 30002683
W 1B 30402703
W 1C 00E687B3
W 1D 40E68833
W 1E 30F02423
W 1F 31002623
# beq taken, bne not taken, jal x18, bne taken, beq not taken
W 20 00000463
W 21 32B02023
W 22 00001463
W 23 32B02223
W 24 0080096F
W 25 32B02423
W 26 33202623
W 27 00209463
W 28 32B02823
W 29 00208463
W 2A 32802A23
# Counting loop to 0x40, count stored at 0x338, then ebreak
W 2B 00000993
W 2C 04000A13
W 2D 00198993
W 2E FF499EE3
W 2F 33302C23
W 30 00100073
# Data preloads and markers
W 85 DEADBEEF
W 86 DEADBEEF
W 8A DEADBEEF
W BF 5A5A5A5A
W C0 00001000
W C1 00000234
W C2 AAAAAAAA
W C3 AAAAAAAA
W C4 5A5A5A5A
W C8 11111111
W C9 11111111
W CA 11111111
W CB 11111111
W CC 11111111
W CD 11111111
W CE 11111111
# Constant region polled during the run
W E0 C0DE0000
W E1 C0DE0001
W E2 C0DE0002
W E3 C0DE0003
G E0 4
# ALU results
R 80 12345668
R 81 12345688
R 82 12345670
R 83 FFFFFFF8
R 84 EDCBA988
R 85 00000001
R 86 00000000
R 87 00000078
R 88 00000555
R 89 EDCBA987
R 8A 00000000
R 8B 12345678
# Loads, stores and neighbors
R BF 5A5A5A5A
R C0 00001000
R C1 00000234
R C2 00001234
R C3 00000DCC
R C4 5A5A5A5A
# Branch markers, link value and loop count
R C8 11111111
R C9 00000555
R CA 11111111
R CB 00000094
R CC 11111111
R CD 00000001
R CE 00000040
# Rerun from reset PC with new operands
S
W C0 7FFFFFFF
W C1 FFFFFFFF
W CE 00000000
G E0 4
R C2 7FFFFFFE
R C3 80000000
R C4 5A5A5A5A
R CE 00000040
R 80 12345668
R 8A 00000000

//--- testbench/riscv_soc_tb.sv
// Run from the project root so the stim path resolves; stim addresses are word addresses
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_soc_tb;

  localparam int CLK_HALF    = 20;
  localparam int LINE_CYCLES = 200;
  localparam int RUN_CYCLES  = 2000;

  logic               clk;
  logic               rst_n;
  logic               run;
  logic               host_req;
  logic               host_we;
  logic [`MEM_AW-1:0] host_addr;
  riscv_pkg::word_t   host_wdata;
  logic               host_ack;
  riscv_pkg::word_t   host_rdata;
  logic               halted;

  // Parsed stim commands and their two hex fields
  byte              cmd_q [$];
  riscv_pkg::word_t arg_a_q [$];
  riscv_pkg::word_t arg_b_q [$];

  // Last word the host wrote per address, expected value for polled reads
  riscv_pkg::word_t shadow [`MEM_WORDS];

  int errors;
  int checks;
  int budget_cycles;

  riscv_soc dut_i (
    .clk, .rst_n, .run,
    .host_req, .host_we, .host_addr, .host_wdata,
    .host_ack, .host_rdata, .halted
  );

  always #(CLK_HALF) clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string name, input riscv_pkg::word_t actual,
                             input riscv_pkg::word_t expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  // Random idle time between host transactions
  task automatic idle_gap();
    int n;
    n = $urandom % 4;
    repeat (n) @(posedge clk);
  endtask

  task automatic host_write(input logic [`MEM_AW-1:0] addr, input riscv_pkg::word_t data);
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    do @(posedge clk); while (!host_ack);
    host_req <= 1'b0;
    host_we  <= 1'b0;
    // Four-phase close, ack must fall first
    do @(posedge clk); while (host_ack);
  endtask

  task automatic host_read(input logic [`MEM_AW-1:0] addr, output riscv_pkg::word_t data);
    @(posedge clk);
    host_req  <= 1'b1;
    host_we   <= 1'b0;
    host_addr <= addr;
    do @(posedge clk); while (!host_ack);
    // rdata valid while ack high
    data = host_rdata;
    host_req <= 1'b0;
    do @(posedge clk); while (host_ack);
  endtask

  // Start the core, poll a constant region until halted
  task automatic run_program(input riscv_pkg::word_t base, input riscv_pkg::word_t count);
    riscv_pkg::word_t   k;
    riscv_pkg::word_t   rd;
    logic [`MEM_AW-1:0] addr;
    k = '0;
    @(posedge clk);
    run <= 1'b1;
    @(posedge clk);
    while (!halted)
    begin
      if (count != 0)
      begin
        addr = base[`MEM_AW-1:0] + k[`MEM_AW-1:0];
        host_read(addr, rd);
        check_value($sformatf("host_rdata[%02h] during run", addr), rd, shadow[addr]);
        k = (k + 1 == count) ? '0 : k + 1;
        idle_gap();
      end
      else
        @(posedge clk);
    end
  endtask

  // halted is sticky and must clear once run is low
  task automatic stop_program();
    @(posedge clk);
    run <= 1'b0;
    repeat (2) @(posedge clk);
    check_value("halted", riscv_pkg::word_t'(halted), '0);
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  initial
  begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, halted never arrived", budget_cycles);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    int               fd;
    int               n_runs;
    string            line;
    byte              c;
    riscv_pkg::word_t a;
    riscv_pkg::word_t b;
    riscv_pkg::word_t rd;
    clk        = 1'b0;
    rst_n      = 1'b0;
    run        = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    errors     = 0;
    checks     = 0;
    n_runs     = 0;
    void'($urandom(22060));

    fd = $fopen("testbench/program_stim.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open the stimulus file testbench/program_stim.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0)
        begin
          c = line.getc(0);
          if (c == "W" || c == "R" || c == "G" || c == "S")
          begin
            a = '0;
            b = '0;
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
            cmd_q.push_back(c);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
            if (c == "G")
              n_runs++;
          end
          // Comments and blank lines skipped
          else if (c != "#" && c != 8'd10 && c != 8'd13 && c != " ")
          begin
            errors++;
            $display("Unknown stimulus command in line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    budget_cycles = cmd_q.size() * LINE_CYCLES + n_runs * RUN_CYCLES + 100;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("halted", riscv_pkg::word_t'(halted), '0);
    check_value("host_ack", riscv_pkg::word_t'(host_ack), '0);

    for (int i = 0; i < cmd_q.size(); i++)
    begin
      a = arg_a_q[i];
      b = arg_b_q[i];
      case (cmd_q[i])
        "W":
        begin
          shadow[a[`MEM_AW-1:0]] = b;
          host_write(a[`MEM_AW-1:0], b);
        end
        "R":
        begin
          host_read(a[`MEM_AW-1:0], rd);
          check_value($sformatf("host_rdata[%02h]", a[`MEM_AW-1:0]), rd, b);
        end
        "G": run_program(a, b);
        "S": stop_program();
        default: ;
      endcase
      idle_gap();
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
